// ==== cfg_frame_loader.sv ====
module cfg_frame_loader #(
    parameter int TX_CREDITS = 2
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  uart_pkg::byte_t         rx_byte_i,
    input  logic                    rx_valid_i,
    input  logic                    credit_ret_i,
    input  logic                    tx_done_i,
    output uart_pkg::byte_t         echo_byte_o,
    output logic                    echo_valid_o,
    output scan_cfg_pkg::scan_cfg_t cfg_o,
    output logic                    start_o
);
    import uart_pkg::*;
    import scan_cfg_pkg::*;

    localparam int CRW   = $clog2(TX_CREDITS + 1);
    localparam int POS_W = $clog2(FRAME_BITS);

    localparam byte_idx_t LAST_IDX = byte_idx_t'(FRAME_BYTES - 1);

    scan_cfg_t       cfg_q;
    byte_idx_t       byte_idx_q;
    byte_idx_t       echo_cnt_q;
    logic [CRW-1:0]  credit_cnt_q;
    logic [CRW-1:0]  credit_cnt_d;
    logic            pending_q;
    byte_t           pend_byte_q;
    byte_t           echo_byte_q;
    logic            echo_valid_q;
    logic            start_q;
    logic [POS_W-1:0] slot_lsb;
    logic            credit_avail;
    logic            issue_pend;
    logic            issue_new;
    logic            spend;

    // bit position of the current byte, first byte at the top
    assign slot_lsb = POS_W'((FRAME_BYTES - 1 - int'(byte_idx_q)) * 8);

    // a returning credit can be spent on the same edge
    assign credit_avail = (credit_cnt_q != '0) || credit_ret_i;
    assign issue_pend   = pending_q && credit_avail;
    assign issue_new    = rx_valid_i && !pending_q && credit_avail;
    assign spend        = issue_pend || issue_new;

    always_comb begin
        credit_cnt_d = credit_cnt_q;
        if (credit_ret_i && !spend) begin
            credit_cnt_d = credit_cnt_q + 1'b1;
        end else if (spend && !credit_ret_i) begin
            credit_cnt_d = credit_cnt_q - 1'b1;
        end
    end

    // field writes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_q      <= '0;
            byte_idx_q <= '0;
        end else if (rx_valid_i) begin
            if (byte_idx_q == ICNT_HI_IDX) begin
                cfg_q.icnt[8:1] <= rx_byte_i;
            end else if (byte_idx_q == ICNT_LO_IDX) begin
                cfg_q.icnt[0] <= rx_byte_i[0];
            end else begin
                cfg_q[slot_lsb +: 8] <= rx_byte_i;
            end
            byte_idx_q <= (byte_idx_q == LAST_IDX) ? '0 : byte_idx_q + 1'b1;
        end
    end

    // echo control and credits
    always_ff @(posedge clk) begin
        if (reset_i) begin
            credit_cnt_q <= CRW'(TX_CREDITS);
            pending_q    <= 1'b0;
            echo_valid_q <= 1'b0;
        end else begin
            credit_cnt_q <= credit_cnt_d;
            echo_valid_q <= spend;
            if (issue_pend) begin
                // a byte landing on the same edge takes the slot
                pending_q <= rx_valid_i;
            end else if (rx_valid_i && !credit_avail) begin
                pending_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_pend) begin
            echo_byte_q <= pend_byte_q;
        end else if (issue_new) begin
            echo_byte_q <= rx_byte_i;
        end
        if (rx_valid_i && (issue_pend || !credit_avail)) begin
            pend_byte_q <= rx_byte_i;
        end
    end

    // start fires once the whole frame is back on the line
    always_ff @(posedge clk) begin
        if (reset_i) begin
            echo_cnt_q <= '0;
            start_q    <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (tx_done_i) begin
                if (echo_cnt_q == LAST_IDX) begin
                    echo_cnt_q <= '0;
                    start_q    <= 1'b1;
                end else begin
                    echo_cnt_q <= echo_cnt_q + 1'b1;
                end
            end
        end
    end

    assign cfg_o        = cfg_q;
    assign echo_byte_o  = echo_byte_q;
    assign echo_valid_o = echo_valid_q;
    assign start_o      = start_q;

    a_credit_range : assert property (
        @(posedge clk) disable iff (reset_i) credit_cnt_q <= CRW'(TX_CREDITS)
    );

    // receiver cannot be stalled, a second byte here would be dropped
    a_no_rx_while_pending : assert property (
        @(posedge clk) disable iff (reset_i) pending_q && !credit_avail |-> !rx_valid_i
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_scan_config_top -f scan_config.f \
    && ./obj_dir/Vtb_scan_config_top | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

// ==== scan_cfg_pkg.sv ====
package scan_cfg_pkg;

    // frame length on the wire
    localparam int FRAME_BYTES = 67;
    localparam int FRAME_BITS  = FRAME_BYTES * 8;

    typedef logic [6:0] byte_idx_t;

    // field types
    typedef logic [7:0]  count8_t;
    typedef logic [31:0] offset32_t;
    typedef logic [15:0] duty16_t;
    typedef logic [31:0] period32_t;
    typedef logic [63:0] period64_t;
    typedef logic [15:0] pix16_t;
    typedef logic [8:0]  icnt_t;

    // integration count arrives split over two bytes
    // upper byte gives bits 8..1, lower byte gives bit 0 from its lsb
    localparam byte_idx_t ICNT_HI_IDX = 7'd54;
    localparam byte_idx_t ICNT_LO_IDX = 7'd55;

    // members in frame byte order, first byte lands in the top bits
    typedef struct packed {
        // frame timing signal
        offset32_t frame_offset;
        duty16_t   frame_duty;
        // pixel timing signal
        offset32_t pixel_offset;
        duty16_t   pixel_duty;
        // laser timing signal
        offset32_t laser_offset;
        duty16_t   laser_duty;
        // periods
        period64_t frame_period;
        period32_t pixel_period;
        period32_t laser_period;
        // repetition counts
        count8_t   frame_count;
        count8_t   pixel_count;
        count8_t   laser_count;
        // pixel grid and scan window
        pix16_t    nx;
        pix16_t    ny;
        pix16_t    x_min;
        pix16_t    x_max;
        pix16_t    y_min;
        pix16_t    y_max;
        // galvo dwell per pixel
        period32_t pixel_time;
        count8_t   zero_point;
        // 16-bit slot, top 7 bits stay zero
        logic [6:0] icnt_rsvd;
        icnt_t      icnt;
        // spad timing signal
        count8_t   spad_count;
        offset32_t spad_offset;
        duty16_t   spad_duty;
        period32_t spad_period;
    } scan_cfg_t;

endpackage

// ==== scan_config.f ====
uart_pkg.sv
scan_cfg_pkg.sv
uart_rx.sv
cfg_frame_loader.sv
uart_tx.sv
scan_config_top.sv
tb_scan_config_top.sv

// ==== scan_config_top.sv ====
module scan_config_top #(
    parameter int CLKS_PER_BIT = 16,
    parameter int TX_CREDITS   = 2
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    rx_i,
    output logic                    tx_o,
    output scan_cfg_pkg::scan_cfg_t cfg_o,
    output logic                    start_o
);
    import uart_pkg::*;

    byte_t rx_byte;
    logic  rx_valid;
    byte_t echo_byte;
    logic  echo_valid;
    logic  credit_ret;
    logic  tx_done;

    // serial input
    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_rx_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .rx_i       (rx_i),
        .rx_byte_o  (rx_byte),
        .rx_valid_o (rx_valid)
    );

    // frame assembly and echo flow
    cfg_frame_loader #(
        .TX_CREDITS (TX_CREDITS)
    ) cfg_frame_loader_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .rx_byte_i    (rx_byte),
        .rx_valid_i   (rx_valid),
        .credit_ret_i (credit_ret),
        .tx_done_i    (tx_done),
        .echo_byte_o  (echo_byte),
        .echo_valid_o (echo_valid),
        .cfg_o        (cfg_o),
        .start_o      (start_o)
    );

    // echo output
    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .TX_CREDITS   (TX_CREDITS)
    ) uart_tx_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .echo_byte_i  (echo_byte),
        .echo_valid_i (echo_valid),
        .credit_ret_o (credit_ret),
        .tx_done_o    (tx_done),
        .tx_o         (tx_o)
    );

endmodule

// ==== tb_scan_config_top.sv ====
module tb_scan_config_top;
    import uart_pkg::*;
    import scan_cfg_pkg::*;

    localparam int CLKS_PER_BIT = 16;
    localparam int TX_CREDITS   = 2;
    localparam int CLK_PERIOD   = 20;
    localparam int CHAR_CLKS    = 10 * CLKS_PER_BIT;
    localparam int SEED         = 32'hfbfa_51cb;
    // bytes ahead of the integration count slot in the frame
    localparam int ICNT_BYTE    = 54;
    // three single frames, two back to back, then 20 bytes and one frame
    localparam int TOTAL_CHARS  = 5 * FRAME_BYTES + 20 + FRAME_BYTES;
    localparam int WATCHDOG     = TOTAL_CHARS * 10 * CLKS_PER_BIT * CLK_PERIOD * 2;

    typedef logic [FRAME_BITS-1:0] wide_t;

    logic      clk;
    logic      reset_i;
    logic      rx_i;
    logic      tx_o;
    scan_cfg_t cfg;
    logic      start;

    byte_t sent_q[$];
    byte_t echo_q[$];
    int    start_at_echo_q[$];
    int    start_width_q[$];
    int    check_errors    = 0;
    int    protocol_errors = 0;
    int    width_cnt       = 0;
    logic  start_prev      = 1'b0;

    scan_config_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .TX_CREDITS   (TX_CREDITS)
    ) scan_config_top_inst (
        .clk     (clk),
        .reset_i (reset_i),
        .rx_i    (rx_i),
        .tx_o    (tx_o),
        .cfg_o   (cfg),
        .start_o (start)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // decode the echo line at mid-bit
    initial begin
        byte_t decoded;
        wait (reset_i === 1'b0);
        forever begin
            @(negedge tx_o);
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            if (tx_o !== 1'b0) begin
                protocol_errors++;
                $display("ERROR: start bit on tx_o was not low at mid-bit");
            end else begin
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    decoded[i] = tx_o;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (tx_o !== 1'b1) begin
                    protocol_errors++;
                    $display("ERROR: stop bit on tx_o was not high");
                end
                echo_q.push_back(decoded);
            end
        end
    end

    // start pulses, with the echo count at the rising edge and the width
    always @(negedge clk) begin
        if (start === 1'b1) begin
            if (!start_prev) begin
                start_at_echo_q.push_back(echo_q.size());
                width_cnt = 1;
            end else begin
                width_cnt++;
            end
        end else if (start_prev) begin
            start_width_q.push_back(width_cnt);
        end
        start_prev = (start === 1'b1);
    end

    initial begin
        #(WATCHDOG);
        $display("ERROR: run did not finish within %0d time units", WATCHDOG);
        $display("checks failed: %0d, protocol errors: %0d", check_errors, protocol_errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic check_value(string name, wide_t expected, wide_t actual);
        if (expected !== actual) begin
            check_errors++;
            $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic apply_reset(int cycles);
        @(posedge clk);
        #2 reset_i = 1'b1;
        repeat (cycles) @(posedge clk);
        #2 reset_i = 1'b0;
    endtask

    task automatic send_byte(byte_t data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #2 rx_i = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        sent_q.push_back(data);
    endtask

    task automatic send_random_frame();
        for (int k = 0; k < FRAME_BYTES; k++) begin
            send_byte(byte_t'($urandom));
        end
    endtask

    task automatic wait_for_starts(int n);
        while (start_at_echo_q.size() < n) @(posedge clk);
        // room for a stray pulse or echo to show up
        repeat (2 * CHAR_CLKS) @(posedge clk);
    endtask

    function automatic scan_cfg_t expected_cfg(int first);
        wide_t     bits;
        scan_cfg_t exp_cfg;
        for (int k = 0; k < FRAME_BYTES; k++) begin
            bits[FRAME_BITS-1-8*k -: 8] = sent_q[first+k];
        end
        exp_cfg           = bits;
        exp_cfg.icnt_rsvd = '0;
        exp_cfg.icnt      = {sent_q[first+ICNT_BYTE], sent_q[first+ICNT_BYTE+1][0]};
        return exp_cfg;
    endfunction

    task automatic check_cfg(string tname, int first);
        scan_cfg_t got;
        got           = cfg;
        got.icnt_rsvd = '0;
        check_value({tname, " cfg"}, wide_t'(expected_cfg(first)), wide_t'(got));
    endtask

    task automatic check_echoes(string tname, int sent_base, int echo_base, int n);
        check_value({tname, " echo count"}, wide_t'(n), wide_t'(echo_q.size() - echo_base));
        if (echo_q.size() - echo_base == n) begin
            for (int i = 0; i < n; i++) begin
                check_value($sformatf("%s echo %0d", tname, i),
                            wide_t'(sent_q[sent_base+i]), wide_t'(echo_q[echo_base+i]));
            end
        end
    endtask

    task automatic check_starts(string tname, int start_base, int echo_base, int n);
        check_value({tname, " start count"}, wide_t'(n),
                    wide_t'(start_at_echo_q.size() - start_base));
        // a pulse still high here has no width recorded
        check_value({tname, " start widths"}, wide_t'(n),
                    wide_t'(start_width_q.size() - start_base));
        if (start_at_echo_q.size() - start_base == n &&
            start_width_q.size() - start_base == n) begin
            for (int i = 0; i < n; i++) begin
                check_value($sformatf("%s start %0d echoes", tname, i),
                            wide_t'(echo_base + FRAME_BYTES * (i + 1)),
                            wide_t'(start_at_echo_q[start_base+i]));
                check_value($sformatf("%s start %0d width", tname, i),
                            wide_t'(1), wide_t'(start_width_q[start_base+i]));
            end
        end
    endtask

    task automatic test_frame_load();
        int sent_base;
        sent_base = sent_q.size();
        send_random_frame();
        wait_for_starts(start_at_echo_q.size() + 1);
        check_cfg("frame_load", sent_base);
    endtask

    task automatic test_echo();
        int sent_base;
        int echo_base;
        sent_base = sent_q.size();
        echo_base = echo_q.size();
        send_random_frame();
        wait_for_starts(start_at_echo_q.size() + 1);
        check_echoes("echo", sent_base, echo_base, FRAME_BYTES);
    endtask

    task automatic test_start_pulse();
        int echo_base;
        int start_base;
        echo_base  = echo_q.size();
        start_base = start_at_echo_q.size();
        send_random_frame();
        wait_for_starts(start_base + 1);
        check_starts("start_pulse", start_base, echo_base, 1);
    endtask

    task automatic test_back_to_back();
        int sent_base;
        int echo_base;
        int start_base;
        sent_base  = sent_q.size();
        echo_base  = echo_q.size();
        start_base = start_at_echo_q.size();
        send_random_frame();
        send_random_frame();
        wait_for_starts(start_base + 2);
        check_starts("back_to_back", start_base, echo_base, 2);
        check_echoes("back_to_back", sent_base, echo_base, 2 * FRAME_BYTES);
        check_cfg("back_to_back", sent_base + FRAME_BYTES);
    endtask

    task automatic test_reset_mid_frame();
        int sent_base;
        int echo_base;
        int start_base;
        echo_base = echo_q.size();
        for (int k = 0; k < 20; k++) begin
            send_byte(byte_t'($urandom));
        end
        // let the echo line go idle before the reset
        while (echo_q.size() < echo_base + 20) @(posedge clk);
        apply_reset(16);
        sent_base  = sent_q.size();
        echo_base  = echo_q.size();
        start_base = start_at_echo_q.size();
        send_random_frame();
        wait_for_starts(start_base + 1);
        check_starts("reset_mid_frame", start_base, echo_base, 1);
        check_cfg("reset_mid_frame", sent_base);
    endtask

    initial begin
        reset_i = 1'b1;
        rx_i    = 1'b1;
        void'($urandom(SEED));
        apply_reset(16);
        test_frame_load();
        test_echo();
        test_start_pulse();
        test_back_to_back();
        test_reset_mid_frame();
        $display("checks failed: %0d, protocol errors: %0d", check_errors, protocol_errors);
        if (check_errors == 0 && protocol_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== uart_pkg.sv ====
package uart_pkg;

    // one serial character
    localparam int DATA_BITS = 8;

    typedef logic [DATA_BITS-1:0] byte_t;

    // clocks elapsed within one bit time
    typedef logic [15:0] baud_cnt_t;

    // position of a data bit inside a character
    typedef logic [$clog2(DATA_BITS)-1:0] bit_idx_t;

endpackage

// ==== uart_rx.sv ====
module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            rx_i,
    output uart_pkg::byte_t rx_byte_o,
    output logic            rx_valid_o
);
    import uart_pkg::*;

    localparam int HALF_BIT = CLKS_PER_BIT / 2;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t state_q;
    baud_cnt_t baud_cnt_q;
    bit_idx_t  bit_idx_q;
    byte_t     shift_q;
    logic      rx_meta_q;
    logic      rx_sync_q;
    logic      valid_q;
    logic      bit_end;
    logic      half_end;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
        end
    end

    assign half_end = (baud_cnt_q == baud_cnt_t'(HALF_BIT - 1));
    assign bit_end  = (baud_cnt_q == baud_cnt_t'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= RX_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            valid_q    <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    baud_cnt_q <= '0;
                    bit_idx_q  <= '0;
                    if (!rx_sync_q) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // mid start bit, glitches go back to idle
                    if (half_end) begin
                        baud_cnt_q <= '0;
                        state_q    <= rx_sync_q ? RX_IDLE : RX_DATA;
                    end else begin
                        baud_cnt_q <= baud_cnt_q + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt_q <= '0;
                        bit_idx_q  <= bit_idx_q + 1'b1;
                        if (bit_idx_q == bit_idx_t'(DATA_BITS - 1)) begin
                            state_q <= RX_STOP;
                        end
                    end else begin
                        baud_cnt_q <= baud_cnt_q + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        baud_cnt_q <= '0;
                        valid_q    <= rx_sync_q;
                        state_q    <= RX_IDLE;
                    end else begin
                        baud_cnt_q <= baud_cnt_q + 1'b1;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && bit_end) begin
            shift_q <= {rx_sync_q, shift_q[DATA_BITS-1:1]};
        end
    end

    assign rx_byte_o  = shift_q;
    assign rx_valid_o = valid_q;

    a_rx_valid_single : assert property (
        @(posedge clk) disable iff (reset_i) rx_valid_o |=> !rx_valid_o
    );

endmodule

// ==== uart_tx.sv ====
module uart_tx #(
    parameter int CLKS_PER_BIT = 16,
    parameter int TX_CREDITS   = 2
) (
    input  logic            clk,
    input  logic            reset_i,
    input  uart_pkg::byte_t echo_byte_i,
    input  logic            echo_valid_i,
    output logic            credit_ret_o,
    output logic            tx_done_o,
    output logic            tx_o
);
    import uart_pkg::*;

    localparam int PTR_W = (TX_CREDITS > 1) ? $clog2(TX_CREDITS) : 1;
    localparam int CNT_W = $clog2(TX_CREDITS + 1);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    byte_t            fifo_mem [TX_CREDITS];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] fifo_cnt_q;

    tx_state_t state_q;
    baud_cnt_t baud_cnt_q;
    bit_idx_t  bit_idx_q;
    byte_t     shift_q;
    logic      tx_q;
    logic      credit_q;
    logic      done_q;
    logic      bit_end;
    logic      pop;

    assign bit_end = (baud_cnt_q == baud_cnt_t'(CLKS_PER_BIT - 1));
    // next byte goes straight from stop into start
    assign pop = (fifo_cnt_q != '0) &&
                 ((state_q == TX_IDLE) || (state_q == TX_STOP && bit_end));

    // byte buffer
    always_ff @(posedge clk) begin
        if (echo_valid_i) begin
            fifo_mem[wr_ptr_q] <= echo_byte_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            fifo_cnt_q <= '0;
        end else begin
            if (echo_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(TX_CREDITS - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(TX_CREDITS - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (echo_valid_i && !pop) begin
                fifo_cnt_q <= fifo_cnt_q + 1'b1;
            end else if (pop && !echo_valid_i) begin
                fifo_cnt_q <= fifo_cnt_q - 1'b1;
            end
        end
    end

    // shifter
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= TX_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            tx_q       <= 1'b1;
            credit_q   <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            credit_q <= pop;
            done_q   <= (state_q == TX_STOP) && bit_end;
            if (pop) begin
                state_q    <= TX_START;
                baud_cnt_q <= '0;
                tx_q       <= 1'b0;
            end else begin
                case (state_q)
                    TX_IDLE: begin
                        tx_q <= 1'b1;
                    end
                    TX_START: begin
                        if (bit_end) begin
                            baud_cnt_q <= '0;
                            bit_idx_q  <= '0;
                            tx_q       <= shift_q[0];
                            state_q    <= TX_DATA;
                        end else begin
                            baud_cnt_q <= baud_cnt_q + 1'b1;
                        end
                    end
                    TX_DATA: begin
                        if (bit_end) begin
                            baud_cnt_q <= '0;
                            bit_idx_q  <= bit_idx_q + 1'b1;
                            if (bit_idx_q == bit_idx_t'(DATA_BITS - 1)) begin
                                tx_q    <= 1'b1;
                                state_q <= TX_STOP;
                            end else begin
                                tx_q <= shift_q[1];
                            end
                        end else begin
                            baud_cnt_q <= baud_cnt_q + 1'b1;
                        end
                    end
                    TX_STOP: begin
                        if (bit_end) begin
                            baud_cnt_q <= '0;
                            state_q    <= TX_IDLE;
                        end else begin
                            baud_cnt_q <= baud_cnt_q + 1'b1;
                        end
                    end
                    default: state_q <= TX_IDLE;
                endcase
            end
        end
    end

    // data register, lsb leaves first
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_q <= fifo_mem[rd_ptr_q];
        end else if (state_q == TX_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign tx_o         = tx_q;
    assign credit_ret_o = credit_q;
    assign tx_done_o    = done_q;

    // loader credits must keep the buffer from overflowing
    a_no_push_when_full : assert property (
        @(posedge clk) disable iff (reset_i) echo_valid_i |-> fifo_cnt_q < CNT_W'(TX_CREDITS)
    );

endmodule
